/* hdl/bubble_config.svh */
`ifndef BUBBLE_CONFIG_SVH
`define BUBBLE_CONFIG_SVH

// bubble buffer geometry
`define BUBBLE_ADDR_W       13          // buffer address bits
`define BUBBLE_DEPTH        8192        // 2**ADDR_W entries, odd/even pair each

// emulated access codes from the bubble controller
`define BUBBLE_ACC_BOOT     3'b110      // bootloader loop access
`define BUBBLE_ACC_USER     3'b111      // user page access

// user page window
`define BUBBLE_PAGE_BASE    7168        // upper three address bits all ones
`define BUBBLE_PAGE_W       10          // cycle bits used inside the window

// line that always shifts out empty bubbles
`define BUBBLE_EMPTY_ADDR   8191

// absolute bubble position counter
`define BUBBLE_POS_W        12

`endif

/* hdl/bubble_pkg.sv */
`include "bubble_config.svh"

package bubble_pkg;

    // access type as presented by the emulated controller
    // anything that is not boot or user counts as idle
    typedef enum logic [2:0]
    {
        ACC_BOOT = `BUBBLE_ACC_BOOT,            // bootloop read, cycle number is address
        ACC_USER = `BUBBLE_ACC_USER             // page read, window at page base
    } access_type_e;

    // one bubble buffer address
    typedef logic [`BUBBLE_ADDR_W-1:0] buf_addr_t;

    // one buffer word
    // bit 1 odd channel, bit 0 even channel
    typedef logic [1:0] bit_pair_t;

endpackage

/* hdl/bubble_host_port.sv */
`timescale 1ns/10ps

module bubble_host_port
    import bubble_pkg::*;
(
    input  logic        bubble_buffer_write_clock,
    input  logic        rst_n,

    // wishbone classic slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [13:0] wb_adr,     // bit 13 selects position register
    input  logic [31:0] wb_dat_i,   // bits 1..0 carry odd/even
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,

    // emulator position, sampled every cycle
    input  logic [11:0] abs_pos,

    // buffer write port
    output logic        wr_en,
    output buf_addr_t   wr_addr,
    output bit_pair_t   wr_data
);

    logic        ack_q;             // single cycle ack
    logic        req;               // new request this cycle
    logic        sel_pos;           // position register selected
    logic [11:0] abs_pos_q;         // registered position
    logic [31:0] dat_q;             // read data, valid with ack

    // a request is only new if we did not ack last cycle
    assign req     = wb_cyc & wb_stb & ~ack_q;
    assign sel_pos = wb_adr[13];

    // write lands in the buffer on the edge that raises ack
    assign wr_en   = req & wb_we & ~sel_pos;
    assign wr_addr = wb_adr[12:0];          // buffer address bits
    assign wr_data = wb_dat_i[1:0];

    always_ff @(posedge bubble_buffer_write_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= req;                   // never high two cycles running
        end
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        abs_pos_q <= abs_pos;               // firmware polls this to stage pages
        if (req && !wb_we && sel_pos)
        begin
            dat_q <= {20'd0, abs_pos_q};    // zero extended position
        end
        else
        begin
            dat_q <= 32'd0;                 // writes and buffer reads return zero
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_o = dat_q;

endmodule

/* hdl/bubble_access_decoder.sv */
`timescale 1ns/10ps
`include "bubble_config.svh"

module bubble_access_decoder
    import bubble_pkg::*;
(
    input  logic         bubble_buffer_write_clock,
    input  logic         rst_n,

    input  access_type_e acc_type,          // boot, user or idle
    input  logic [12:0]  bout_cycle_num,    // bubble output cycle
    input  logic [1:0]   bout_ticks,        // bit 0 load, bit 1 clear

    output buf_addr_t    rd_addr,           // registered buffer read address
    output logic [1:0]   ticks_d            // ticks aligned with ram data
);

    access_type_e acc_q;                    // input stage
    logic [12:0]  cyc_q;
    logic [1:0]   ticks_s1;
    logic [1:0]   ticks_s2;                 // aligned with rd_addr
    logic [1:0]   ticks_s3;                 // aligned with rd_data
    buf_addr_t    addr_next;
    buf_addr_t    addr_q;

    // address select from the sampled access
    always_comb
    begin
        case (acc_q)
            ACC_BOOT:
            begin
                addr_next = cyc_q;          // bootloop is addressed directly
            end
            ACC_USER:
            begin
                // page window, low bits from the cycle number
                addr_next = buf_addr_t'(`BUBBLE_PAGE_BASE)
                          | buf_addr_t'(cyc_q[`BUBBLE_PAGE_W-1:0]);
            end
            default:
            begin
                addr_next = buf_addr_t'(`BUBBLE_EMPTY_ADDR);    // empty line
            end
        endcase
    end

    always_ff @(posedge bubble_buffer_write_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_q    <= access_type_e'(3'b000); // idle
            cyc_q    <= 13'd0;
            ticks_s1 <= 2'b00;
            ticks_s2 <= 2'b00;
            ticks_s3 <= 2'b00;
            addr_q   <= buf_addr_t'(`BUBBLE_EMPTY_ADDR);
        end
        else
        begin
            acc_q    <= acc_type;
            cyc_q    <= bout_cycle_num;
            ticks_s1 <= bout_ticks;
            addr_q   <= addr_next;          // edge N+1
            ticks_s2 <= ticks_s1;
            ticks_s3 <= ticks_s2;           // extra stage covers the ram read
        end
    end

    assign rd_addr = addr_q;
    assign ticks_d = ticks_s3;

endmodule

/* hdl/bubble_buffer_ram.sv */
`timescale 1ns/10ps
`include "bubble_config.svh"

module bubble_buffer_ram
    import bubble_pkg::*;
(
    input  logic      bubble_buffer_write_clock,

    // host write port
    input  logic      wr_en,                // active high strobe
    input  buf_addr_t wr_addr,
    input  bit_pair_t wr_data,

    // emulator read port
    input  buf_addr_t rd_addr,
    output bit_pair_t rd_data               // registered, one cycle latency
);

    // Layout is owned by the host: bootloop image from 0, page window
    // from the page base, empty propagation line at the top address.
    bit_pair_t mem [0:`BUBBLE_DEPTH-1];
    bit_pair_t rd_q;

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;        // store odd/even pair
        end
    end

    // same edge write and read to one address gives old data
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        rd_q <= mem[rd_addr];
    end

    assign rd_data = rd_q;

endmodule

/* hdl/bubble_output_stage.sv */
`timescale 1ns/10ps

module bubble_output_stage
    import bubble_pkg::*;
(
    input  logic       bubble_buffer_write_clock,
    input  logic       rst_n,

    input  logic [1:0] ticks_d,             // delayed output ticks
    input  bit_pair_t  rd_data,             // buffer word for this access

    output bit_pair_t  bout_data            // odd/even channel outputs
);

    localparam int TICK_LOAD  = 0;          // copy buffer word
    localparam int TICK_CLEAR = 1;          // drop both channels

    bit_pair_t bout_q;

    always_ff @(posedge bubble_buffer_write_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bout_q <= 2'b00;                // no bubbles out of reset
        end
        else if (ticks_d[TICK_CLEAR])
        begin
            bout_q <= 2'b00;                // clear wins over load
        end
        else if (ticks_d[TICK_LOAD])
        begin
            bout_q <= rd_data;
        end
        // no tick, channels hold
    end

    assign bout_data = bout_q;

endmodule

/* hdl/bubble_interface.sv */
`timescale 1ns/10ps
`include "bubble_config.svh"

module bubble_interface
    import bubble_pkg::*;
(
    input  logic                     bubble_buffer_write_clock,
    input  logic                     rst_n,

    // host side, wishbone classic
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`BUBBLE_ADDR_W:0]  wb_adr,        // extra top bit for position reg
    input  logic [31:0]              wb_dat_i,
    output logic [31:0]              wb_dat_o,
    output logic                     wb_ack,

    // emulator side
    input  access_type_e             acc_type,
    input  logic [`BUBBLE_ADDR_W-1:0] bout_cycle_num,
    input  logic [1:0]               bout_ticks,    // bit 0 load, bit 1 clear
    input  logic [`BUBBLE_POS_W-1:0] abs_pos,
    output bit_pair_t                bout_data
);

    logic       wr_en;                      // host to ram
    buf_addr_t  wr_addr;
    bit_pair_t  wr_data;
    buf_addr_t  rd_addr;                    // decoder to ram
    logic [1:0] ticks_d;                    // decoder to output stage
    bit_pair_t  rd_data;                    // ram to output stage

    bubble_host_port u_host_port
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .rst_n                     (rst_n),
        .wb_cyc                    (wb_cyc),
        .wb_stb                    (wb_stb),
        .wb_we                     (wb_we),
        .wb_adr                    (wb_adr),
        .wb_dat_i                  (wb_dat_i),
        .wb_dat_o                  (wb_dat_o),
        .wb_ack                    (wb_ack),
        .abs_pos                   (abs_pos),
        .wr_en                     (wr_en),
        .wr_addr                   (wr_addr),
        .wr_data                   (wr_data)
    );

    // inputs at N, address after N+1
    bubble_access_decoder u_decoder
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .rst_n                     (rst_n),
        .acc_type                  (acc_type),
        .bout_cycle_num            (bout_cycle_num),
        .bout_ticks                (bout_ticks),
        .rd_addr                   (rd_addr),
        .ticks_d                   (ticks_d)
    );

    // data after N+2
    bubble_buffer_ram u_ram
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .wr_en                     (wr_en),
        .wr_addr                   (wr_addr),
        .wr_data                   (wr_data),
        .rd_addr                   (rd_addr),
        .rd_data                   (rd_data)
    );

    // channels after N+3
    bubble_output_stage u_output
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .rst_n                     (rst_n),
        .ticks_d                   (ticks_d),
        .rd_data                   (rd_data),
        .bout_data                 (bout_data)
    );

endmodule

/* tb/tb_bubble_interface.sv */
`timescale 1ns/10ps
`include "bubble_config.svh"

module tb_bubble_interface
    import bubble_pkg::*;
();

    localparam int BOOT_TOP   = 4106;                   // bootloop image size
    localparam int PAGE_USED  = 584;                    // page window entries filled
    localparam int FILL_COUNT = BOOT_TOP + PAGE_USED + 1;
    localparam int N_POS      = 4;
    localparam int N_BOOT     = 300;
    localparam int N_USER     = 300;
    localparam int N_IDLE     = 50;
    localparam int N_MIX      = 600;
    localparam int MIX_WRITES = 190;                    // 3 cycles each, fits in N_MIX
    localparam int DRAIN      = 8;
    localparam int SCHED      = 3 + 2 + 3 * FILL_COUNT + 5 * N_POS
                              + N_BOOT + N_USER + N_IDLE + N_MIX + DRAIN;
    localparam int LIMIT      = 4 * SCHED;              // watchdog limit

    logic                      bubble_buffer_write_clock;
    logic                      rst_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`BUBBLE_ADDR_W:0]   wb_adr;
    logic [31:0]               wb_dat_i;
    logic [31:0]               wb_dat_o;
    logic                      wb_ack;
    access_type_e              acc_type;
    logic [`BUBBLE_ADDR_W-1:0] bout_cycle_num;
    logic [1:0]                bout_ticks;
    logic [`BUBBLE_POS_W-1:0]  abs_pos;
    bit_pair_t                 bout_data;

    integer      seed;                                  // $random state
    int          cycles;                                // watchdog counter
    string       test_name;
    logic        compare_on;
    logic [1:0]  shadow [0:`BUBBLE_DEPTH-1];            // mirror of host writes
    logic [17:0] pipe_q [$];                            // {code, cycle, ticks} in flight
    logic [17:0] item;
    logic [1:0]  exp_bout;                              // model of channel outputs

    bubble_interface u_bubble_interface
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .rst_n                     (rst_n),
        .wb_cyc                    (wb_cyc),
        .wb_stb                    (wb_stb),
        .wb_we                     (wb_we),
        .wb_adr                    (wb_adr),
        .wb_dat_i                  (wb_dat_i),
        .wb_dat_o                  (wb_dat_o),
        .wb_ack                    (wb_ack),
        .acc_type                  (acc_type),
        .bout_cycle_num            (bout_cycle_num),
        .bout_ticks                (bout_ticks),
        .abs_pos                   (abs_pos),
        .bout_data                 (bout_data)
    );

    initial
    begin
        bubble_buffer_write_clock = 1'b0;
        forever
        begin
            #4 bubble_buffer_write_clock = ~bubble_buffer_write_clock;   // 8 ns period
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp)
        begin
            $display("Fail %s (%s): expected %h, actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // decoder rule applied to the shadow copy
    function automatic logic [1:0] expected_word(input logic [2:0] code,
                                                 input logic [12:0] cyc);
        int addr;
        case (code)
            `BUBBLE_ACC_BOOT: addr = cyc;                              // direct
            `BUBBLE_ACC_USER: addr = `BUBBLE_PAGE_BASE + cyc[9:0];     // page window
            default:          addr = `BUBBLE_EMPTY_ADDR;               // empty line
        endcase
        return shadow[addr];
    endfunction

    function automatic logic [12:0] boot_cycle();
        logic [31:0] r;
        r = $random(seed);
        r = r % BOOT_TOP;                                   // stay in written image
        return r[12:0];
    endfunction

    // random upper bits, low bits limited to the filled part of the window
    function automatic logic [12:0] user_cycle();
        logic [31:0] r;
        logic [15:0] low;
        r   = $random(seed);
        low = r[15:0] % (PAGE_USED + 1);
        if (low == PAGE_USED)
        begin
            low = 16'd1023;                                 // top of window, empty line
        end
        return {r[28:26], low[9:0]};
    endfunction

    task automatic write_buffer(input int addr, input logic [1:0] data);
        logic [31:0] r;
        r = $random(seed);
        @(negedge bubble_buffer_write_clock);
        shadow[addr] = data;
        wb_cyc       = 1'b1;
        wb_stb       = 1'b1;
        wb_we        = 1'b1;
        wb_adr       = {1'b0, addr[12:0]};
        wb_dat_i     = {r[31:2], data};                     // upper bits are ignored
        @(negedge bubble_buffer_write_clock);
        check_value("wb_ack on write", 32'd1, {31'd0, wb_ack});
        @(negedge bubble_buffer_write_clock);               // request held over ack edge
        check_value("wb_ack after write", 32'd0, {31'd0, wb_ack});     // no double ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_position(input logic [11:0] exp_pos);
        @(negedge bubble_buffer_write_clock);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = 14'h2000;                                  // position register
        @(negedge bubble_buffer_write_clock);
        check_value("wb_ack on read", 32'd1, {31'd0, wb_ack});
        check_value("wb_dat_o position", {20'd0, exp_pos}, wb_dat_o);
        @(negedge bubble_buffer_write_clock);               // request held over ack edge
        check_value("wb_ack after read", 32'd0, {31'd0, wb_ack});
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic emulate_access(input logic [2:0] code, input logic [12:0] cyc,
                                  input logic [1:0] ticks);
        @(negedge bubble_buffer_write_clock);
        acc_type       = access_type_e'(code);
        bout_cycle_num = cyc;
        bout_ticks     = ticks;
    endtask

    // follows each sampled access through the three pipeline stages
    always @(posedge bubble_buffer_write_clock)
    begin
        if (rst_n)
        begin
            pipe_q.push_back({acc_type, bout_cycle_num, bout_ticks});
            if (pipe_q.size() > 3)
            begin
                item = pipe_q.pop_front();
                if (item[1])
                begin
                    exp_bout = 2'b00;                       // clear beats load
                end
                else if (item[0])
                begin
                    exp_bout = expected_word(item[17:15], item[14:2]);
                end
                // neither tick, hold
            end
        end
    end

    always @(negedge bubble_buffer_write_clock)
    begin
        if (compare_on)
        begin
            check_value("bout_data", {30'd0, exp_bout}, {30'd0, bout_data});
        end
    end

    always @(posedge bubble_buffer_write_clock)
    begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("Test failed");
            $fatal(1, "stopped by watchdog");
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [11:0] pos;
        int          waddr;
        seed           = 12289;
        cycles         = 0;
        test_name      = "reset";
        compare_on     = 1'b0;
        exp_bout       = 2'b00;
        rst_n          = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_i       = '0;
        acc_type       = access_type_e'(3'b000);            // idle
        bout_cycle_num = '0;
        bout_ticks     = 2'b00;
        abs_pos        = '0;
        repeat (3) @(negedge bubble_buffer_write_clock);
        rst_n      = 1'b1;
        compare_on = 1'b1;

        @(negedge bubble_buffer_write_clock);
        check_value("wb_ack after reset", 32'd0, {31'd0, wb_ack});
        check_value("bout_data after reset", 32'd0, {30'd0, bout_data});

        test_name = "buffer fill";
        for (int a = 0; a < BOOT_TOP; a++)
        begin
            r = $random(seed);
            write_buffer(a, r[1:0]);
        end
        for (int a = `BUBBLE_PAGE_BASE; a < `BUBBLE_PAGE_BASE + PAGE_USED; a++)
        begin
            r = $random(seed);
            write_buffer(a, r[1:0]);
        end
        write_buffer(`BUBBLE_EMPTY_ADDR, 2'b00);            // empty line reads as 00

        test_name = "position read";
        for (int i = 0; i < N_POS; i++)
        begin
            r = $random(seed);
            pos = r[11:0];
            @(negedge bubble_buffer_write_clock);
            abs_pos = pos;
            @(negedge bubble_buffer_write_clock);
            read_position(pos);
        end

        test_name = "boot access";
        for (int i = 0; i < N_BOOT; i++)
        begin
            emulate_access(`BUBBLE_ACC_BOOT, boot_cycle(), 2'b01);
        end

        test_name = "user access";
        for (int i = 0; i < N_USER; i++)
        begin
            emulate_access(`BUBBLE_ACC_USER, user_cycle(), 2'b01);
        end

        test_name = "idle access";
        for (int i = 0; i < N_IDLE; i++)
        begin
            r = $random(seed);
            emulate_access(3'(r[7:0] % 6), r[20:8], 2'b01);     // codes 0 to 5
        end

        test_name = "tick mix";
        fork
            begin
                for (int i = 0; i < N_MIX; i++)
                begin
                    r = $random(seed);
                    case (r[1:0])
                        2'd0:    emulate_access(`BUBBLE_ACC_BOOT, boot_cycle(), r[9:8]);
                        2'd1:    emulate_access(`BUBBLE_ACC_USER, user_cycle(), r[9:8]);
                        default: emulate_access(3'(r[7:2] % 6), r[22:10], r[9:8]);
                    endcase
                end
            end
            begin
                for (int i = 0; i < MIX_WRITES; i++)
                begin
                    // addresses between image and window are never read
                    waddr = BOOT_TOP + ($unsigned($random(seed)) % (`BUBBLE_PAGE_BASE - BOOT_TOP));
                    r     = $random(seed);
                    write_buffer(waddr, r[1:0]);
                end
            end
        join

        emulate_access(3'b000, 13'd0, 2'b00);               // park idle, hold outputs
        repeat (DRAIN) @(negedge bubble_buffer_write_clock);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/bubble_pkg.sv
hdl/bubble_host_port.sv
hdl/bubble_access_decoder.sv
hdl/bubble_buffer_ram.sv
hdl/bubble_output_stage.sv
hdl/bubble_interface.sv
tb/tb_bubble_interface.sv

/* Bender.yml */
package:
  name: bubble_interface

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bubble_pkg.sv
      - hdl/bubble_host_port.sv
      - hdl/bubble_access_decoder.sv
      - hdl/bubble_buffer_ram.sv
      - hdl/bubble_output_stage.sv
      - hdl/bubble_interface.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_bubble_interface.sv
